// ==== verilog/noc_proto_pkg.sv ====
`default_nettype none

package noc_proto_pkg;

	// one byte on the serial link
	typedef logic [7:0] byte_t;

	// node ids, carried raw from the command
	typedef logic [7:0] node_id_t;

	// byte count, must reach 128
	typedef logic [7:0] len_t;

	// length codes from the command byte, count is 2**code
	typedef logic [1:0] alen_t;
	typedef logic [2:0] dlen_t;

	// low three bits of every command byte
	typedef enum logic [2:0] {
		NOP        = 3'd0,
		READ       = 3'd1,
		WRITE      = 3'd2,
		READ_RESP  = 3'd3,
		WRITE_RESP = 3'd4,
		MESSAGE    = 3'd5
	} opcode_e;

	// error field, top two bits of a response command byte
	typedef logic [1:0] err_t;

	localparam err_t ERR_NONE = 2'd0;
	localparam err_t ERR_DROPPED = 2'd1;

	localparam int MAX_DATA_BYTES = 128;

endpackage

`default_nettype wire

// ==== verilog/noc_dev_pkg.sv ====
`default_nettype none

package noc_dev_pkg;

	// device word, eight byte lanes
	typedef logic [63:0] word_t;

	// lane index inside a word
	typedef logic [2:0] lane_t;

	// firstin every 25 delivered words
	localparam int FRAME_WORDS = 25;

	// pending write responses
	localparam int RESP_DEPTH = 4;

	// wide enough for FRAME_WORDS - 1
	typedef logic [4:0] frame_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/noc_if.sv ====
`default_nettype none

// data bytes of a write, decoder to packer
interface noc_byte_if;
	import noc_proto_pkg::*;

	logic byte_valid;
	byte_t byte_data;
	// final data byte of the write
	logic byte_last;
	// stable from first data byte through byte_last
	node_id_t dest_id;
	node_id_t src_id;

	// no ready, link never stalls
	modport source (output byte_valid, byte_data, byte_last, dest_id, src_id);
	modport sink (input byte_valid, byte_data, byte_last, dest_id, src_id);

endinterface

// write response, valid/ready
interface noc_resp_if;
	import noc_proto_pkg::*;

	logic valid;
	logic ready;
	node_id_t dest_id;
	node_id_t src_id;
	// data bytes that reached the device
	len_t length;
	err_t err;

	modport source (output valid, dest_id, src_id, length, err, input ready);
	modport sink (input valid, dest_id, src_id, length, err, output ready);

endinterface

`default_nettype wire

// ==== verilog/noc_cmd_decode.sv ====
`default_nettype none

module noc_cmd_decode (
	input  logic clk,
	input  logic reset,
	input  logic tod_ctl,
	input  noc_proto_pkg::byte_t tod_data,
	noc_byte_if.source bytes
);
	import noc_proto_pkg::*;

	typedef enum logic [2:0] {IDLE, DEST, SRC, ADDR, DATA} state_e;

	state_e state;
	alen_t alen_q;
	dlen_t dlen_q;
	// bytes seen in the current address or data field
	len_t count;
	len_t addr_total;
	len_t data_total;
	opcode_e opcode;

	// command byte is {alen, dlen, opcode}
	assign opcode = opcode_e'(tod_data[2:0]);
	assign addr_total = len_t'(1) << alen_q;
	assign data_total = len_t'(1) << dlen_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			alen_q <= '0;
			dlen_q <= '0;
			count <= '0;
			bytes.byte_valid <= 1'b0;
			bytes.byte_last <= 1'b0;
		end else begin
			bytes.byte_valid <= 1'b0;
			bytes.byte_last <= 1'b0;
			if (tod_ctl) begin
				// any command byte restarts parsing
				count <= '0;
				alen_q <= tod_data[7:6];
				dlen_q <= tod_data[5:3];
				state <= (opcode == WRITE) ? DEST : IDLE;
			end else begin
				case (state)
					DEST: state <= SRC;
					SRC: state <= ADDR;
					ADDR: begin
						// address bytes are only counted
						if (count == addr_total - 1'b1) begin
							count <= '0;
							state <= DATA;
						end else begin
							count <= count + 1'b1;
						end
					end
					DATA: begin
						bytes.byte_valid <= 1'b1;
						if (count == data_total - 1'b1) begin
							bytes.byte_last <= 1'b1;
							count <= '0;
							state <= IDLE;
						end else begin
							count <= count + 1'b1;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if (!tod_ctl) begin
			case (state)
				DEST: bytes.dest_id <= tod_data;
				SRC: bytes.src_id <= tod_data;
				DATA: bytes.byte_data <= tod_data;
				default: ;
			endcase
		end
	end

	// a write must run to its last data byte before the next command
	a_no_ctl_mid_write: assert property (@(posedge clk) disable iff (reset)
		(state != IDLE) |-> !tod_ctl);

endmodule

`default_nettype wire

// ==== verilog/noc_word_packer.sv ====
`default_nettype none

module noc_word_packer (
	input  logic clk,
	input  logic reset,
	noc_byte_if.sink bytes,
	input  logic stopin,
	output logic pushin,
	output logic firstin,
	output noc_dev_pkg::word_t din,
	noc_resp_if.source resp
);
	import noc_proto_pkg::*;
	import noc_dev_pkg::*;

	// partial word with upper lanes kept zero
	word_t acc;
	word_t word_next;
	lane_t lane;
	// word in din this cycle
	logic emit_q;
	logic emit_last_q;
	len_t emit_bytes_q;
	frame_cnt_t frame_cnt;
	// running totals of the current write
	len_t len_acc;
	logic drop_acc;
	node_id_t dest_q;
	node_id_t src_q;
	// response waiting for ready
	logic resp_pending;
	len_t resp_len_q;
	err_t resp_err_q;
	logic final_emit;
	len_t len_now;
	err_t err_now;

	always_comb begin
		word_next = acc;
		word_next[{lane, 3'b000} +: 8] = bytes.byte_data;
	end

	// stopin high refuses the word
	assign pushin = emit_q & ~stopin;
	assign firstin = pushin & (frame_cnt == '0);
	assign final_emit = emit_q & emit_last_q;
	assign len_now = len_acc + (pushin ? emit_bytes_q : len_t'(0));
	assign err_now = (drop_acc | (emit_q & stopin)) ? ERR_DROPPED : ERR_NONE;

	// response shows up with the final word, then holds
	assign resp.valid = resp_pending | final_emit;
	assign resp.length = resp_pending ? resp_len_q : len_now;
	assign resp.err = resp_pending ? resp_err_q : err_now;
	assign resp.dest_id = dest_q;
	assign resp.src_id = src_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			acc <= '0;
			lane <= '0;
			din <= '0;
			emit_q <= 1'b0;
			emit_last_q <= 1'b0;
			frame_cnt <= '0;
			len_acc <= '0;
			drop_acc <= 1'b0;
			resp_pending <= 1'b0;
		end else begin
			emit_q <= 1'b0;
			if (bytes.byte_valid) begin
				if (lane == '1 || bytes.byte_last) begin
					emit_q <= 1'b1;
					emit_last_q <= bytes.byte_last;
					din <= word_next;
					acc <= '0;
					lane <= '0;
				end else begin
					acc <= word_next;
					lane <= lane + 1'b1;
				end
			end
			// frame count moves on delivered words only
			if (pushin) begin
				frame_cnt <= (frame_cnt == frame_cnt_t'(FRAME_WORDS - 1)) ? '0 : frame_cnt + 1'b1;
			end
			if (emit_q) begin
				len_acc <= final_emit ? '0 : len_now;
				drop_acc <= final_emit ? 1'b0 : (drop_acc | stopin);
			end
			if (resp.valid && resp.ready) begin
				resp_pending <= 1'b0;
			end else if (final_emit) begin
				resp_pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bytes.byte_valid) begin
			emit_bytes_q <= len_t'(lane) + 1'b1;
		end
		if (bytes.byte_valid && bytes.byte_last) begin
			dest_q <= bytes.dest_id;
			src_q <= bytes.src_id;
		end
		if (final_emit) begin
			resp_len_q <= len_now;
			resp_err_q <= err_now;
		end
	end

	// each word is offered to the device for one cycle only
	a_emit_one_cycle: assert property (@(posedge clk) disable iff (reset)
		emit_q |=> !emit_q);

	// a held response must leave before the next write ends
	a_resp_drained: assert property (@(posedge clk) disable iff (reset)
		final_emit |-> !resp_pending);

	a_len_bound: assert property (@(posedge clk) disable iff (reset)
		len_acc <= MAX_DATA_BYTES);

endmodule

`default_nettype wire

// ==== verilog/noc_resp_fifo.sv ====
`default_nettype none

module noc_resp_fifo (
	input  logic clk,
	input  logic reset,
	noc_resp_if.sink in,
	noc_resp_if.source out
);
	import noc_proto_pkg::*;
	import noc_dev_pkg::*;

	typedef logic [$clog2(RESP_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(RESP_DEPTH+1)-1:0] cnt_t;

	node_id_t dest_mem [RESP_DEPTH];
	node_id_t src_mem [RESP_DEPTH];
	len_t len_mem [RESP_DEPTH];
	err_t err_mem [RESP_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic do_write;
	logic do_read;

	assign in.ready = (count != cnt_t'(RESP_DEPTH));
	assign do_write = in.valid & in.ready;
	assign do_read = out.valid & out.ready;

	// fall-through, head entry always on the output
	assign out.valid = (count != '0);
	assign out.dest_id = dest_mem[rd_ptr];
	assign out.src_id = src_mem[rd_ptr];
	assign out.length = len_mem[rd_ptr];
	assign out.err = err_mem[rd_ptr];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= (wr_ptr == ptr_t'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == ptr_t'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop keeps the count
			if (do_write && !do_read) begin
				count <= count + 1'b1;
			end else if (do_read && !do_write) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_write) begin
			dest_mem[wr_ptr] <= in.dest_id;
			src_mem[wr_ptr] <= in.src_id;
			len_mem[wr_ptr] <= in.length;
			err_mem[wr_ptr] <= in.err;
		end
	end

	// writes are spaced wider than serialization, so never full
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		in.valid |-> in.ready);

endmodule

`default_nettype wire

// ==== verilog/noc_resp_serializer.sv ====
`default_nettype none

module noc_resp_serializer (
	input  logic clk,
	input  logic reset,
	noc_resp_if.sink resp,
	output logic frm_ctl,
	output noc_proto_pkg::byte_t frm_data
);
	import noc_proto_pkg::*;

	// state names the byte now on frm
	typedef enum logic [2:0] {IDLE, CMD, DEST, SRC, LEN} state_e;

	state_e state;
	node_id_t dest_q;
	node_id_t src_q;
	len_t len_q;

	assign resp.ready = (state == IDLE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			frm_ctl <= 1'b1;
			frm_data <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (resp.valid) begin
						// err, zero length codes, WRITE_RESP
						frm_ctl <= 1'b1;
						frm_data <= {resp.err, 3'b000, WRITE_RESP};
						state <= CMD;
					end
				end
				CMD: begin
					// ids swap, reply goes back to the sender
					frm_ctl <= 1'b0;
					frm_data <= src_q;
					state <= DEST;
				end
				DEST: begin
					frm_data <= dest_q;
					state <= SRC;
				end
				SRC: begin
					frm_data <= len_q;
					state <= LEN;
				end
				default: begin
					// back to NOP bytes
					frm_ctl <= 1'b1;
					frm_data <= '0;
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (resp.valid && resp.ready) begin
			dest_q <= resp.dest_id;
			src_q <= resp.src_id;
			len_q <= resp.length;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/noc_intf.sv ====
`default_nettype none

module noc_intf (
	input  logic clk,
	input  logic reset,
	input  logic tod_ctl,
	input  noc_proto_pkg::byte_t tod_data,
	input  logic stopin,
	output logic pushin,
	output logic firstin,
	output noc_dev_pkg::word_t din,
	output logic frm_ctl,
	output noc_proto_pkg::byte_t frm_data
);

	noc_byte_if byte_link ();
	// packer to queue
	noc_resp_if resp_in ();
	// queue to serializer
	noc_resp_if resp_out ();

	noc_cmd_decode u_decode (
		.clk      (clk),
		.reset    (reset),
		.tod_ctl  (tod_ctl),
		.tod_data (tod_data),
		.bytes    (byte_link.source)
	);

	noc_word_packer u_packer (
		.clk     (clk),
		.reset   (reset),
		.bytes   (byte_link.sink),
		.stopin  (stopin),
		.pushin  (pushin),
		.firstin (firstin),
		.din     (din),
		.resp    (resp_in.source)
	);

	noc_resp_fifo u_resp_fifo (
		.clk   (clk),
		.reset (reset),
		.in    (resp_in.sink),
		.out   (resp_out.source)
	);

	noc_resp_serializer u_serializer (
		.clk      (clk),
		.reset    (reset),
		.resp     (resp_out.sink),
		.frm_ctl  (frm_ctl),
		.frm_data (frm_data)
	);

endmodule

`default_nettype wire

// ==== verification/noc_intf_tb.sv ====
`default_nettype none

module noc_intf_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import noc_proto_pkg::*;
	import noc_dev_pkg::*;

	localparam int N_CMDS = 40;
	// 60 cycles per write plus margin for reset and drain
	localparam int CYCLE_LIMIT = 60 * N_CMDS + 200;

	logic clk;
	logic reset;
	logic tod_ctl;
	byte_t tod_data;
	logic stopin;
	logic pushin;
	logic firstin;
	word_t din;
	logic frm_ctl;
	byte_t frm_data;

	logic [31:0] lfsr;
	int step = 0;
	int cycles = 0;

	// expected words that reach the device
	word_t exp_words [0:1023];
	int word_wr = 0;
	int word_rd = 0;

	// expected write responses, in order
	err_t exp_err [0:63];
	node_id_t exp_src [0:63];
	node_id_t exp_dest [0:63];
	len_t exp_len [0:63];
	int resp_wr = 0;
	int resp_rd = 0;
	// position of the response byte now on frm (0 while idle)
	int frm_pos = 0;

	// words in flight that stopin settles two steps after their last byte
	int sched_step [$];
	word_t sched_word [$];
	int sched_bytes [$];
	logic sched_final [$];
	node_id_t sched_src [$];
	node_id_t sched_dest [$];

	// totals of the write being delivered
	len_t cmd_len;
	logic cmd_drop;

	int err_word = 0;
	int err_bp = 0;
	int err_frame = 0;
	int err_resp = 0;
	int err_idle = 0;

	noc_intf UUT (
		.clk      (clk),
		.reset    (reset),
		.tod_ctl  (tod_ctl),
		.tod_data (tod_data),
		.stopin   (stopin),
		.pushin   (pushin),
		.firstin  (firstin),
		.din      (din),
		.frm_ctl  (frm_ctl),
		.frm_data (frm_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
	task automatic draw(input int n, output logic [7:0] v);
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[6:0], fb};
		end
	endtask

	// settle the word whose emit cycle is this step
	task automatic settle_emit();
		if (sched_step.size() > 0 && sched_step[0] == step) begin
			if (!stopin) begin
				exp_words[word_wr] = sched_word[0];
				word_wr++;
				cmd_len += len_t'(sched_bytes[0]);
			end else begin
				// refused by the device
				cmd_drop = 1'b1;
			end
			if (sched_final[0]) begin
				exp_err[resp_wr] = cmd_drop ? ERR_DROPPED : ERR_NONE;
				exp_src[resp_wr] = sched_src[0];
				exp_dest[resp_wr] = sched_dest[0];
				exp_len[resp_wr] = cmd_len;
				resp_wr++;
				cmd_len = '0;
				cmd_drop = 1'b0;
			end
			void'(sched_step.pop_front());
			void'(sched_word.pop_front());
			void'(sched_bytes.pop_front());
			void'(sched_final.pop_front());
			void'(sched_src.pop_front());
			void'(sched_dest.pop_front());
		end
	endtask

	// one link byte per falling edge with stopin high about 1 in 8
	task automatic drive_byte(input logic ctl, input byte_t data);
		logic [7:0] r;
		@(negedge clk);
		draw(3, r);
		tod_ctl = ctl;
		tod_data = data;
		stopin = (r[2:0] == 3'd0);
		step++;
		settle_emit();
	endtask

	task automatic send_write();
		logic [7:0] r;
		logic [1:0] alen;
		logic [2:0] dlen;
		logic [7:0] dest;
		logic [7:0] src;
		word_t w;
		int lane;
		draw(2, r);
		alen = r[1:0];
		draw(3, r);
		dlen = r[2:0];
		draw(8, dest);
		draw(8, src);
		drive_byte(1'b1, {alen, dlen, WRITE});
		drive_byte(1'b0, dest);
		drive_byte(1'b0, src);
		for (int i = 0; i < (1 << alen); i++) begin
			draw(8, r);
			drive_byte(1'b0, r);
		end
		w = '0;
		lane = 0;
		for (int i = 0; i < (1 << dlen); i++) begin
			draw(8, r);
			drive_byte(1'b0, r);
			// first byte goes in lane 0 and unused lanes stay zero
			w[lane * 8 +: 8] = r;
			lane++;
			if (lane == 8 || i == (1 << dlen) - 1) begin
				sched_step.push_back(step + 2);
				sched_word.push_back(w);
				sched_bytes.push_back(lane);
				sched_final.push_back(i == (1 << dlen) - 1);
				sched_src.push_back(src);
				sched_dest.push_back(dest);
				w = '0;
				lane = 0;
			end
		end
	endtask

	task automatic print_result(input string name, input int n);
		if (n == 0) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: %0d failures", name, n);
		end
	endtask

	// delivered word and response byte tracking
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			word_rd <= 0;
			resp_rd <= 0;
			frm_pos <= 0;
		end else begin
			if (pushin) begin
				word_rd <= word_rd + 1;
			end
			case (frm_pos)
				0: if (frm_ctl && frm_data != 8'h00) frm_pos <= 1;
				3: begin
					frm_pos <= 0;
					resp_rd <= resp_rd + 1;
				end
				default: frm_pos <= frm_pos + 1;
			endcase
		end
	end

	a_word: assert property (@(posedge clk) disable iff (reset)
		pushin |-> (word_rd < word_wr && din == exp_words[word_rd]))
	else begin
		err_word++;
		$display("[FAIL] %0t din %h, expected %h", $time, din, exp_words[word_rd]);
	end

	a_backpressure: assert property (@(posedge clk) disable iff (reset)
		stopin |-> !pushin)
	else begin
		err_bp++;
		$display("[FAIL] %0t pushin high while stopin high", $time);
	end

	// firstin on delivered words 0, 25, 50 ...
	a_frame: assert property (@(posedge clk) disable iff (reset)
		pushin |-> (firstin == (word_rd % FRAME_WORDS == 0)))
	else begin
		err_frame++;
		$display("[FAIL] %0t firstin %b on delivered word %0d", $time, firstin, word_rd);
	end

	a_frame_push: assert property (@(posedge clk) disable iff (reset)
		firstin |-> pushin)
	else begin
		err_frame++;
		$display("[FAIL] %0t firstin without pushin", $time);
	end

	a_resp_cmd: assert property (@(posedge clk) disable iff (reset)
		(frm_pos == 0 && frm_ctl && frm_data != 8'h00) |->
		(resp_rd < resp_wr && frm_data == {exp_err[resp_rd], 3'b000, WRITE_RESP}))
	else begin
		err_resp++;
		$display("[FAIL] %0t response command byte %h, expected err %0d",
			$time, frm_data, exp_err[resp_rd]);
	end

	// ids come back swapped
	a_resp_src: assert property (@(posedge clk) disable iff (reset)
		(frm_pos == 1) |-> (!frm_ctl && frm_data == exp_src[resp_rd]))
	else begin
		err_resp++;
		$display("[FAIL] %0t response src %h, expected %h", $time, frm_data, exp_src[resp_rd]);
	end

	a_resp_dest: assert property (@(posedge clk) disable iff (reset)
		(frm_pos == 2) |-> (!frm_ctl && frm_data == exp_dest[resp_rd]))
	else begin
		err_resp++;
		$display("[FAIL] %0t response dest %h, expected %h", $time, frm_data, exp_dest[resp_rd]);
	end

	a_resp_len: assert property (@(posedge clk) disable iff (reset)
		(frm_pos == 3) |-> (!frm_ctl && frm_data == exp_len[resp_rd]))
	else begin
		err_resp++;
		$display("[FAIL] %0t response length %0d, expected %0d", $time, frm_data, exp_len[resp_rd]);
	end

	// NOP bytes between responses
	a_idle: assert property (@(posedge clk) disable iff (reset)
		(frm_pos == 0) |-> frm_ctl)
	else begin
		err_idle++;
		$display("[FAIL] %0t frm_ctl low outside a response", $time);
	end

	a_reset_state: assert property (@(posedge clk)
		reset |-> (!pushin && !firstin && din == '0 && frm_ctl && frm_data == 8'h00))
	else begin
		err_idle++;
		$display("[FAIL] %0t outputs not at reset values", $time);
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		logic [7:0] r;
		int total;
		lfsr = 32'hf6f;
		reset = 1'b1;
		tod_ctl = 1'b1;
		tod_data = 8'h00;
		stopin = 1'b0;
		cmd_len = '0;
		cmd_drop = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int c = 0; c < N_CMDS; c++) begin
			// zero to three NOP bytes before each write
			draw(2, r);
			for (int g = 0; g < r[1:0]; g++) begin
				drive_byte(1'b1, 8'h00);
			end
			send_write();
		end
		// drain last words and responses
		while (sched_step.size() > 0 || resp_rd < resp_wr) begin
			drive_byte(1'b1, 8'h00);
		end
		// idle window after the last response
		repeat (8) drive_byte(1'b1, 8'h00);
		a_word_count: assert (word_rd == word_wr && sched_step.size() == 0) else begin
			err_bp++;
			$display("[FAIL] %0t %0d words delivered, expected %0d", $time, word_rd, word_wr);
		end
		a_resp_count: assert (resp_rd == resp_wr && resp_wr == N_CMDS) else begin
			err_idle++;
			$display("[FAIL] %0t %0d responses seen, expected %0d", $time, resp_rd, N_CMDS);
		end
		print_result("word assembly", err_word);
		print_result("back-pressure", err_bp);
		print_result("frame marking", err_frame);
		print_result("response format", err_resp);
		print_result("idle and reset", err_idle);
		total = err_word + err_bp + err_frame + err_resp + err_idle;
		$display("totals: %0d failures, %0d writes, %0d words, %0d responses, %0d cycles",
			total, N_CMDS, word_rd, resp_rd, cycles);
		if (total == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/noc_proto_pkg.sv
verilog/noc_dev_pkg.sv
verilog/noc_if.sv
verilog/noc_cmd_decode.sv
verilog/noc_word_packer.sv
verilog/noc_resp_fifo.sv
verilog/noc_resp_serializer.sv
verilog/noc_intf.sv
verification/noc_intf_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the noc_intf testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module noc_intf_tb \
	-f src.f -o noc_intf_sim \
	&& ./obj_dir/noc_intf_sim 2>&1 | tee "$log" \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -qF "Errors found" "$log" && { echo "FAILED"; exit 1; } || { echo "PASSED"; exit 0; }
